//--- testbench/ooo_cases.txt
// Columns in hex: op rdest rsrc0 rsrc1 imm expected, with op 0 li, 1 add, 2 sub, 3 mul
// Expected is the value the destination holds after sequential execution
1 1 0 0 00000000 00000000
0 1 0 0 00000007 00000007
0 2 0 0 fffffffe fffffffe
3 3 1 2 00000000 fffffff2
1 4 1 1 00000000 0000000e
1 5 3 4 00000000 00000000
2 6 4 1 00000000 00000007
3 7 6 6 00000000 00000031
2 1 0 1 00000000 fffffff9
1 2 7 1 00000000 0000002a
3 3 2 2 00000000 000006e4
3 4 3 1 00000000 ffffcfc4
0 5 0 0 00000001 00000001
0 6 0 0 00000002 00000002
0 7 0 0 00000003 00000003
0 5 0 0 00000004 00000004
0 6 0 0 00000005 00000005
0 7 0 0 00000006 00000006
0 0 0 0 00000008 00000008
0 1 0 0 00000009 00000009
0 2 0 0 0000000a 0000000a
1 3 5 6 00000000 00000009
// End marker
f f f f ffffffff ffffffff

//--- build.f
source/ooo_pkg.sv
source/reg_map.sv
source/reorder_buffer.sv
source/exec_unit.sv
source/cdb_arbiter.sv
source/ooo_core_top.sv
testbench/ooo_core_sva.sv
testbench/ooo_core_tb.sv

//--- Makefile
# Verilator build and run of the out-of-order core testbench

VERILATOR ?= verilator
TOP       ?= ooo_core_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'TEST PASSED'

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/ooo_core_tb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the out-of-order core with clock, reset, stimulus read
// from the case file, an in-order retirement checker and a cycle timeout
////////////////////////////////////////////////////////////////////////////

module ooo_core_tb;

    localparam int CLK_PERIOD      = 40;
    localparam int RST_CYCLES      = 8;
    localparam int CYCLES_PER_CASE = 30;
    localparam int MAX_CASES       = 32;
    // Words on one line of the case file
    localparam int CASE_WORDS      = 6;
    localparam int RAND_SEED       = 93;

    logic               clk;
    logic               n_rst;
    logic               disp_en;
    ooo_pkg::op_t       disp_op;
    ooo_pkg::reg_addr_t disp_rdest;
    ooo_pkg::reg_addr_t disp_rsrc0;
    ooo_pkg::reg_addr_t disp_rsrc1;
    ooo_pkg::data_t     disp_imm;
    logic               disp_stall;
    logic               retire_en;
    ooo_pkg::reg_addr_t retire_rdest;
    ooo_pkg::data_t     retire_data;

    // Flat copy of the case file, six words per instruction
    logic [31:0] case_mem [MAX_CASES*CASE_WORDS];

    int num_cases    = 0;
    int retired      = 0;
    int check_cnt    = 0;
    int value_errs   = 0;
    int other_errs   = 0;
    int stall_cycles = 0;
    int cycle_cnt    = 0;

    ooo_core_top i_dut (
        .clk, .n_rst, .disp_en, .disp_op, .disp_rdest, .disp_rsrc0, .disp_rsrc1, .disp_imm,
        .disp_stall, .retire_en, .retire_rdest, .retire_data
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // Label for one case in error lines, built from its index, op and destination
    function automatic string case_name(input int idx);
        ooo_pkg::op_t op;
        op = ooo_pkg::op_t'(case_mem[idx*CASE_WORDS][1:0]);
        return $sformatf("case %0d %s r%0d", idx, op.name(), case_mem[idx*CASE_WORDS+1]);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_cnt++;
        if (actual !== expected) begin
            value_errs++;
            $display("** Error: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic print_counts();
        $display("Checks: %0d, value errors: %0d, other errors: %0d, retired: %0d of %0d",
                 check_cnt, value_errs, other_errs, retired, num_cases);
    endtask

    // Retire outputs come from DUT state only, so they are steady at the falling edge
    // and each high sample stands for exactly one retirement at the next rising edge
    always @(negedge clk) begin
        if (retire_en) begin
            if (retired >= num_cases) begin
                other_errs++;
                $display("Error: an extra instruction retired after every case had retired");
            end else begin
                check_value($sformatf("%s rdest", case_name(retired)),
                            case_mem[retired*CASE_WORDS+1], 32'(retire_rdest));
                check_value($sformatf("%s data", case_name(retired)),
                            case_mem[retired*CASE_WORDS+5], retire_data);
            end
            retired++;
        end
    end

    // Budget of cycles that grows with the number of cases
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= RST_CYCLES + CYCLES_PER_CASE * num_cases) begin
            $display("Error: the run did not finish within %0d cycles", cycle_cnt);
            print_counts();
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        int idx;
        int base;
        int gap;
        void'($urandom(RAND_SEED));
        n_rst      = 1'b0;
        disp_en    = 1'b0;
        disp_op    = ooo_pkg::op_li;
        disp_rdest = '0;
        disp_rsrc0 = '0;
        disp_rsrc1 = '0;
        disp_imm   = '0;
        $readmemh("testbench/ooo_cases.txt", case_mem);
        // The list ends at the marker line whose op word is f
        while (num_cases < MAX_CASES && case_mem[num_cases*CASE_WORDS] != 32'hf) begin
            num_cases++;
        end
        if (num_cases == 0) begin
            other_errs++;
            $display("Error: the case file holds no instructions");
        end
        repeat (RST_CYCLES) @(negedge clk);
        n_rst = 1'b1;
        // Nothing is in flight yet, so neither stall nor retire may be up
        check_value("reset disp_stall", 32'd0, 32'(disp_stall));
        check_value("reset retire_en", 32'd0, 32'(retire_en));
        for (idx = 0; idx < num_cases; idx++) begin
            base = idx * CASE_WORDS;
            gap  = int'($urandom_range(3));
            repeat (gap) @(negedge clk);
            disp_op    = ooo_pkg::op_t'(case_mem[base][1:0]);
            disp_rdest = case_mem[base+1][2:0];
            disp_rsrc0 = case_mem[base+2][2:0];
            disp_rsrc1 = case_mem[base+3][2:0];
            disp_imm   = case_mem[base+4];
            disp_en    = 1'b1;
            // The stall has settled a quarter period after the falling edge
            // and stays put until the next rising edge
            #(CLK_PERIOD/4);
            while (disp_stall) begin
                stall_cycles++;
                @(negedge clk);
                #(CLK_PERIOD/4);
            end
            @(negedge clk);
            disp_en = 1'b0;
        end
        while (retired < num_cases) @(posedge clk);
        // A few idle cycles let a duplicated retirement show up
        repeat (4) @(posedge clk);
        if (retired != num_cases) begin
            other_errs++;
            $display("Error: %0d instructions retired but %0d were dispatched",
                     retired, num_cases);
        end
        if (stall_cycles == 0) begin
            other_errs++;
            $display("Error: dispatch was never held off by the core");
        end
        print_counts();
        if (value_errs == 0 && other_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/ooo_core_sva.sv
////////////////////////////////////////////////////////////////////////////
// Concurrent assertions on the reorder buffer pointers and handshakes,
// attached to every reorder_buffer instance through bind
////////////////////////////////////////////////////////////////////////////

module ooo_core_sva (
    input logic          clk,
    input logic          n_rst,
    input logic          full,
    input logic          empty,
    input logic          ret_en,
    input logic          disp_stall,
    input ooo_pkg::ptr_t head_ptr,
    input ooo_pkg::ptr_t tail_ptr
);

    // Nothing may retire from an empty buffer
    no_retire_when_empty: assert property (
        @(posedge clk) disable iff (!n_rst) empty |-> !ret_en
    ) else $error("retirement while the reorder buffer is empty");

    // A full buffer has to hold off dispatch
    stall_when_full: assert property (
        @(posedge clk) disable iff (!n_rst) full |-> disp_stall
    ) else $error("reorder buffer is full but dispatch is not stalled");

    // Occupancy never exceeds the depth, so the tail cannot overtake the head
    tail_behind_head: assert property (
        @(posedge clk) disable iff (!n_rst)
            ooo_pkg::ptr_t'(tail_ptr - head_ptr) <= ooo_pkg::ptr_t'(ooo_pkg::ROB_DEPTH)
    ) else $error("reorder buffer tail pointer passed the head pointer");

endmodule

bind reorder_buffer ooo_core_sva i_sva (
    .clk, .n_rst, .full, .empty, .ret_en, .disp_stall, .head_ptr, .tail_ptr
);

//--- source/ooo_core_top.sv
////////////////////////////////////////////////////////////////////////////
// Core top level wiring the register map, reorder buffer, adder unit,
// multiplier unit and bus arbiter
////////////////////////////////////////////////////////////////////////////

module ooo_core_top (
    input  logic               clk,
    input  logic               n_rst,
    input  logic               disp_en,
    input  ooo_pkg::op_t       disp_op,
    input  ooo_pkg::reg_addr_t disp_rdest,
    input  ooo_pkg::reg_addr_t disp_rsrc0,
    input  ooo_pkg::reg_addr_t disp_rsrc1,
    input  ooo_pkg::data_t     disp_imm,
    output logic               disp_stall,
    output logic               retire_en,
    output ooo_pkg::reg_addr_t retire_rdest,
    output ooo_pkg::data_t     retire_data
);

    // Rename and retire traffic between buffer and map
    ooo_pkg::reg_addr_t lookup_rsrc0, lookup_rsrc1, tag_wr_rdest;
    ooo_pkg::data_t     lookup_data0, lookup_data1;
    ooo_pkg::tag_t      lookup_tag0, lookup_tag1, tag_wr_tag, ret_tag;
    logic               lookup_rdy0, lookup_rdy1, tag_wr_en;

    // Issue side, shared by both units
    logic               alu_issue, mul_issue, alu_busy, mul_busy;
    ooo_pkg::op_t       issue_op;
    ooo_pkg::tag_t      issue_tag, src_tag0, src_tag1;
    ooo_pkg::data_t     src_data0, src_data1;
    logic               src_rdy0, src_rdy1;

    // Result bus and the unit requests feeding it
    logic               alu_req, mul_req, alu_grant, mul_grant, cdb_en;
    ooo_pkg::tag_t      alu_tag, mul_tag, cdb_tag;
    ooo_pkg::data_t     alu_data, mul_data, cdb_data;

    reg_map i_map (
        .clk, .n_rst, .lookup_rsrc0, .lookup_rsrc1, .tag_wr_en, .tag_wr_rdest, .tag_wr_tag,
        .ret_en(retire_en), .ret_rdest(retire_rdest), .ret_tag, .ret_data(retire_data),
        .lookup_data0, .lookup_data1, .lookup_tag0, .lookup_tag1, .lookup_rdy0, .lookup_rdy1
    );

    reorder_buffer i_rob (
        .clk, .n_rst, .disp_en, .disp_op, .disp_rdest, .disp_rsrc0, .disp_rsrc1, .disp_imm,
        .lookup_data0, .lookup_data1, .lookup_tag0, .lookup_tag1, .lookup_rdy0, .lookup_rdy1,
        .alu_busy, .mul_busy, .cdb_en, .cdb_tag, .cdb_data, .disp_stall,
        .lookup_rsrc0, .lookup_rsrc1, .tag_wr_en, .tag_wr_rdest, .tag_wr_tag,
        .alu_issue, .mul_issue, .issue_op, .issue_tag, .src_data0, .src_data1,
        .src_tag0, .src_tag1, .src_rdy0, .src_rdy1,
        .ret_en(retire_en), .ret_rdest(retire_rdest), .ret_tag, .ret_data(retire_data)
    );

    exec_unit #(.LATENCY(ooo_pkg::ALU_LATENCY)) i_alu (
        .clk, .n_rst, .issue(alu_issue), .issue_op, .issue_tag, .src_data0, .src_data1,
        .src_tag0, .src_tag1, .src_rdy0, .src_rdy1, .cdb_en, .cdb_tag, .cdb_data,
        .grant(alu_grant), .busy(alu_busy), .req(alu_req), .res_tag(alu_tag),
        .res_data(alu_data)
    );

    exec_unit #(.LATENCY(ooo_pkg::MUL_LATENCY)) i_mul (
        .clk, .n_rst, .issue(mul_issue), .issue_op, .issue_tag, .src_data0, .src_data1,
        .src_tag0, .src_tag1, .src_rdy0, .src_rdy1, .cdb_en, .cdb_tag, .cdb_data,
        .grant(mul_grant), .busy(mul_busy), .req(mul_req), .res_tag(mul_tag),
        .res_data(mul_data)
    );

    cdb_arbiter i_arb (
        .clk, .n_rst, .alu_req, .mul_req, .alu_tag, .mul_tag, .alu_data, .mul_data,
        .alu_grant, .mul_grant, .cdb_en, .cdb_tag, .cdb_data
    );

endmodule

//--- source/cdb_arbiter.sv
////////////////////////////////////////////////////////////////////////////
// Round-robin arbiter for the adder and multiplier, driving the CDB
////////////////////////////////////////////////////////////////////////////

module cdb_arbiter (
    input  logic           clk,
    input  logic           n_rst,
    input  logic           alu_req,
    input  logic           mul_req,
    input  ooo_pkg::tag_t  alu_tag,
    input  ooo_pkg::tag_t  mul_tag,
    input  ooo_pkg::data_t alu_data,
    input  ooo_pkg::data_t mul_data,
    output logic           alu_grant,
    output logic           mul_grant,
    output logic           cdb_en,
    output ooo_pkg::tag_t  cdb_tag,
    output ooo_pkg::data_t cdb_data
);

    // Set when the multiplier held the bus last
    logic mul_last;

    // On a tie the unit that lost last time wins, the other keeps waiting
    assign alu_grant = alu_req && (!mul_req || mul_last);
    assign mul_grant = mul_req && !alu_grant;

    assign cdb_en   = alu_req || mul_req;
    assign cdb_tag  = mul_grant ? mul_tag : alu_tag;
    assign cdb_data = mul_grant ? mul_data : alu_data;

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            mul_last <= 1'b0;
        end else if (alu_grant) begin
            mul_last <= 1'b0;
        end else if (mul_grant) begin
            mul_last <= 1'b1;
        end
    end

endmodule

//--- source/exec_unit.sv
////////////////////////////////////////////////////////////////////////////
// One-entry reservation slot in front of a functional unit of fixed
// latency, which requests the common data bus once its result is ready
////////////////////////////////////////////////////////////////////////////

module exec_unit #(
    parameter int LATENCY = 1
) (
    input  logic           clk,
    input  logic           n_rst,
    input  logic           issue,
    input  ooo_pkg::op_t   issue_op,
    input  ooo_pkg::tag_t  issue_tag,
    input  ooo_pkg::data_t src_data0,
    input  ooo_pkg::data_t src_data1,
    input  ooo_pkg::tag_t  src_tag0,
    input  ooo_pkg::tag_t  src_tag1,
    input  logic           src_rdy0,
    input  logic           src_rdy1,
    input  logic           cdb_en,
    input  ooo_pkg::tag_t  cdb_tag,
    input  ooo_pkg::data_t cdb_data,
    input  logic           grant,
    output logic           busy,
    output logic           req,
    output ooo_pkg::tag_t  res_tag,
    output ooo_pkg::data_t res_data
);

    ooo_pkg::exec_state_t state;
    ooo_pkg::lat_cnt_t    cnt;
    logic                 rdy_a;
    logic                 rdy_b;
    logic                 hit_a;
    logic                 hit_b;
    ooo_pkg::op_t         op;
    ooo_pkg::tag_t        tag;
    ooo_pkg::tag_t        tag_a;
    ooo_pkg::tag_t        tag_b;
    ooo_pkg::data_t       opnd_a;
    ooo_pkg::data_t       opnd_b;
    ooo_pkg::data_t       result;
    ooo_pkg::data_t       result_q;

    // A waiting operand picks up its value when its producer broadcasts
    assign hit_a = !rdy_a && cdb_en && (cdb_tag == tag_a);
    assign hit_b = !rdy_b && cdb_en && (cdb_tag == tag_b);

    // Arithmetic wraps at 32 bits
    always_comb begin
        case (op)
            ooo_pkg::op_add: result = opnd_a + opnd_b;
            ooo_pkg::op_sub: result = opnd_a - opnd_b;
            ooo_pkg::op_mul: result = opnd_a * opnd_b;
            default:         result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            state <= ooo_pkg::exec_idle;
            cnt   <= '0;
            rdy_a <= 1'b0;
            rdy_b <= 1'b0;
        end else begin
            case (state)
                ooo_pkg::exec_idle: if (issue) begin
                    rdy_a <= src_rdy0;
                    rdy_b <= src_rdy1;
                    cnt   <= '0;
                    // Ready operands let the unit start in the next cycle
                    state <= (src_rdy0 && src_rdy1) ? ooo_pkg::exec_run : ooo_pkg::exec_wait;
                end
                ooo_pkg::exec_wait: begin
                    if (hit_a) rdy_a <= 1'b1;
                    if (hit_b) rdy_b <= 1'b1;
                    if ((rdy_a || hit_a) && (rdy_b || hit_b)) begin
                        state <= ooo_pkg::exec_run;
                    end
                end
                ooo_pkg::exec_run: begin
                    if (cnt == ooo_pkg::lat_cnt_t'(LATENCY - 1)) begin
                        state <= ooo_pkg::exec_done;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                // Keep requesting until the arbiter lets us onto the bus
                ooo_pkg::exec_done: if (grant) state <= ooo_pkg::exec_idle;
                default: state <= ooo_pkg::exec_idle;
            endcase
        end
    end

    // Operands and result
    always_ff @(posedge clk) begin
        if (issue) begin
            op     <= issue_op;
            tag    <= issue_tag;
            tag_a  <= src_tag0;
            tag_b  <= src_tag1;
            opnd_a <= src_data0;
            opnd_b <= src_data1;
        end else if (state == ooo_pkg::exec_wait) begin
            if (hit_a) opnd_a <= cdb_data;
            if (hit_b) opnd_b <= cdb_data;
        end
        if (state == ooo_pkg::exec_run) begin
            result_q <= result;
        end
    end

    assign busy     = (state != ooo_pkg::exec_idle);
    assign req      = (state == ooo_pkg::exec_done);
    assign res_tag  = tag;
    assign res_data = result_q;

endmodule

//--- source/reorder_buffer.sv
////////////////////////////////////////////////////////////////////////////
// Circular reorder buffer with dispatch acceptance, operand resolution,
// steering to the adder or multiplier and in-order retirement
////////////////////////////////////////////////////////////////////////////

module reorder_buffer (
    input  logic               clk,
    input  logic               n_rst,
    input  logic               disp_en,
    input  ooo_pkg::op_t       disp_op,
    input  ooo_pkg::reg_addr_t disp_rdest,
    input  ooo_pkg::reg_addr_t disp_rsrc0,
    input  ooo_pkg::reg_addr_t disp_rsrc1,
    input  ooo_pkg::data_t     disp_imm,
    input  ooo_pkg::data_t     lookup_data0,
    input  ooo_pkg::data_t     lookup_data1,
    input  ooo_pkg::tag_t      lookup_tag0,
    input  ooo_pkg::tag_t      lookup_tag1,
    input  logic               lookup_rdy0,
    input  logic               lookup_rdy1,
    input  logic               alu_busy,
    input  logic               mul_busy,
    input  logic               cdb_en,
    input  ooo_pkg::tag_t      cdb_tag,
    input  ooo_pkg::data_t     cdb_data,
    output logic               disp_stall,
    output ooo_pkg::reg_addr_t lookup_rsrc0,
    output ooo_pkg::reg_addr_t lookup_rsrc1,
    output logic               tag_wr_en,
    output ooo_pkg::reg_addr_t tag_wr_rdest,
    output ooo_pkg::tag_t      tag_wr_tag,
    output logic               alu_issue,
    output logic               mul_issue,
    output ooo_pkg::op_t       issue_op,
    output ooo_pkg::tag_t      issue_tag,
    output ooo_pkg::data_t     src_data0,
    output ooo_pkg::data_t     src_data1,
    output ooo_pkg::tag_t      src_tag0,
    output ooo_pkg::tag_t      src_tag1,
    output logic               src_rdy0,
    output logic               src_rdy1,
    output logic               ret_en,
    output ooo_pkg::reg_addr_t ret_rdest,
    output ooo_pkg::tag_t      ret_tag,
    output ooo_pkg::data_t     ret_data
);

    // Slot contents, the ready bit being the only control state
    logic               slot_rdy   [ooo_pkg::ROB_DEPTH];
    ooo_pkg::reg_addr_t slot_rdest [ooo_pkg::ROB_DEPTH];
    ooo_pkg::data_t     slot_data  [ooo_pkg::ROB_DEPTH];

    ooo_pkg::ptr_t head_ptr;
    ooo_pkg::ptr_t tail_ptr;
    ooo_pkg::tag_t head_idx;
    ooo_pkg::tag_t tail_idx;
    logic          full;
    logic          empty;
    logic          is_alu_op;
    logic          is_mul_op;
    logic          accept;

    // Resolve one source in priority order: map, same-cycle bus, then slot
    function automatic void resolve(
        input  logic           map_rdy,
        input  ooo_pkg::tag_t  map_tag,
        input  ooo_pkg::data_t map_data,
        output ooo_pkg::data_t data,
        output ooo_pkg::tag_t  tag,
        output logic           rdy
    );
        tag = map_tag;
        if (map_rdy) begin
            data = map_data;
            rdy  = 1'b1;
        end else if (cdb_en && (cdb_tag == map_tag)) begin
            data = cdb_data;
            rdy  = 1'b1;
        end else begin
            // Not ready here means the unit snoops the bus for this tag
            data = slot_data[map_tag];
            rdy  = slot_rdy[map_tag];
        end
    endfunction

    assign head_idx = head_ptr[ooo_pkg::TAG_WIDTH-1:0];
    assign tail_idx = tail_ptr[ooo_pkg::TAG_WIDTH-1:0];
    // Same slot index with opposite wrap bits means every slot is in flight
    assign full  = (tail_ptr == {~head_ptr[ooo_pkg::TAG_WIDTH], head_idx});
    assign empty = (tail_ptr == head_ptr);

    // Multiply goes to the multiplier, add and subtract to the adder
    assign is_alu_op = (disp_op == ooo_pkg::op_add) || (disp_op == ooo_pkg::op_sub);
    assign is_mul_op = (disp_op == ooo_pkg::op_mul);

    assign disp_stall = full || (is_alu_op && alu_busy) || (is_mul_op && mul_busy);
    assign accept     = disp_en && !disp_stall;

    // Rename the destination to the tail slot
    assign lookup_rsrc0 = disp_rsrc0;
    assign lookup_rsrc1 = disp_rsrc1;
    assign tag_wr_en    = accept;
    assign tag_wr_rdest = disp_rdest;
    assign tag_wr_tag   = tail_idx;

    assign alu_issue = accept && is_alu_op;
    assign mul_issue = accept && is_mul_op;
    assign issue_op  = disp_op;
    assign issue_tag = tail_idx;

    always_comb begin
        resolve(lookup_rdy0, lookup_tag0, lookup_data0, src_data0, src_tag0, src_rdy0);
        resolve(lookup_rdy1, lookup_tag1, lookup_data1, src_data1, src_tag1, src_rdy1);
    end

    // The ready head retires in the same cycle it is seen
    assign ret_en    = !empty && slot_rdy[head_idx];
    assign ret_rdest = slot_rdest[head_idx];
    assign ret_tag   = head_idx;
    assign ret_data  = slot_data[head_idx];

    // Dispatch and bus writes never hit the same slot, so both may land
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            for (int i = 0; i < ooo_pkg::ROB_DEPTH; i++) begin
                slot_rdy[i] <= 1'b0;
            end
        end else begin
            // A load immediate carries its result already
            if (accept) begin
                slot_rdy[tail_idx] <= (disp_op == ooo_pkg::op_li);
            end
            if (cdb_en) begin
                slot_rdy[cdb_tag] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            slot_rdest[tail_idx] <= disp_rdest;
            slot_data[tail_idx]  <= disp_imm;
        end
        if (cdb_en) begin
            slot_data[cdb_tag] <= cdb_data;
        end
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            head_ptr <= '0;
            tail_ptr <= '0;
        end else begin
            if (accept) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            if (ret_en) begin
                head_ptr <= head_ptr + 1'b1;
            end
        end
    end

endmodule

//--- source/reg_map.sv
////////////////////////////////////////////////////////////////////////////
// Register status table with committed value, ready bit and newest
// producer tag per architectural register, plus two lookup ports
////////////////////////////////////////////////////////////////////////////

module reg_map (
    input  logic              clk,
    input  logic              n_rst,
    input  ooo_pkg::reg_addr_t lookup_rsrc0,
    input  ooo_pkg::reg_addr_t lookup_rsrc1,
    input  logic              tag_wr_en,
    input  ooo_pkg::reg_addr_t tag_wr_rdest,
    input  ooo_pkg::tag_t     tag_wr_tag,
    input  logic              ret_en,
    input  ooo_pkg::reg_addr_t ret_rdest,
    input  ooo_pkg::tag_t     ret_tag,
    input  ooo_pkg::data_t    ret_data,
    output ooo_pkg::data_t    lookup_data0,
    output ooo_pkg::data_t    lookup_data1,
    output ooo_pkg::tag_t     lookup_tag0,
    output ooo_pkg::tag_t     lookup_tag1,
    output logic              lookup_rdy0,
    output logic              lookup_rdy1
);

    // Per register state
    ooo_pkg::data_t reg_value [ooo_pkg::NUM_REGS];
    ooo_pkg::tag_t  reg_tag   [ooo_pkg::NUM_REGS];
    logic           reg_rdy   [ooo_pkg::NUM_REGS];

    // Lookups read the stored state directly, so a dispatching instruction
    // sees the map as it was before its own destination gets renamed
    assign lookup_data0 = reg_value[lookup_rsrc0];
    assign lookup_tag0  = reg_tag[lookup_rsrc0];
    assign lookup_rdy0  = reg_rdy[lookup_rsrc0];

    assign lookup_data1 = reg_value[lookup_rsrc1];
    assign lookup_tag1  = reg_tag[lookup_rsrc1];
    assign lookup_rdy1  = reg_rdy[lookup_rsrc1];

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            // Every register starts out committed with the value zero
            for (int i = 0; i < ooo_pkg::NUM_REGS; i++) begin
                reg_value[i] <= '0;
                reg_tag[i]   <= '0;
                reg_rdy[i]   <= 1'b1;
            end
        end else begin
            // Retirement always commits the architectural value
            if (ret_en) begin
                reg_value[ret_rdest] <= ret_data;
                // Only the newest producer may mark the register ready again
                if (reg_tag[ret_rdest] == ret_tag) begin
                    reg_rdy[ret_rdest] <= 1'b1;
                end
            end
            // A rename in the same cycle comes last and therefore wins,
            // leaving the register waiting on the younger producer
            if (tag_wr_en) begin
                reg_rdy[tag_wr_rdest] <= 1'b0;
                reg_tag[tag_wr_rdest] <= tag_wr_tag;
            end
        end
    end

endmodule

//--- source/ooo_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared widths, depths and unit latencies of the out-of-order core
// Value, register, tag and pointer types plus the operation and unit enums
////////////////////////////////////////////////////////////////////////////

package ooo_pkg;

    // Operand width and architectural register count
    localparam int DATA_WIDTH = 32;
    localparam int NUM_REGS   = 8;
    localparam int REG_WIDTH  = $clog2(NUM_REGS);

    // Reorder buffer geometry, where a tag is simply a slot number
    localparam int ROB_DEPTH = 8;
    localparam int TAG_WIDTH = $clog2(ROB_DEPTH);

    // Cycles spent in the run state by each execution unit
    localparam int ALU_LATENCY = 1;
    localparam int MUL_LATENCY = 3;

    // The latency counter has to cover the slower unit
    localparam int LAT_CNT_WIDTH = $clog2(MUL_LATENCY + 1);

    typedef logic [DATA_WIDTH-1:0]    data_t;
    typedef logic [REG_WIDTH-1:0]     reg_addr_t;
    typedef logic [TAG_WIDTH-1:0]     tag_t;
    // Pointer with one extra wrap bit to tell full from empty
    typedef logic [TAG_WIDTH:0]       ptr_t;
    typedef logic [LAT_CNT_WIDTH-1:0] lat_cnt_t;

    // Encoding matches the op column of the stimulus file
    typedef enum logic [1:0] {
        op_li  = 2'd0,
        op_add = 2'd1,
        op_sub = 2'd2,
        op_mul = 2'd3
    } op_t;

    typedef enum logic [1:0] {
        exec_idle = 2'd0,
        exec_wait = 2'd1,
        exec_run  = 2'd2,
        exec_done = 2'd3
    } exec_state_t;

endpackage
